//--- rtl/mips_ctrl_pkg.sv
`default_nettype none

package mips_ctrl_pkg;

	// instruction field positions
	localparam int op_msb    = 31;
	localparam int op_lsb    = 26;
	localparam int rs_msb    = 25;
	localparam int rs_lsb    = 21;
	localparam int rt_msb    = 20;
	localparam int rt_lsb    = 16;
	localparam int funct_msb = 5;
	localparam int funct_lsb = 0;

	localparam int reg_addr_w = 5; // width of a register specifier

	// destination register select
	localparam logic [1:0] reg_dst_rd = 2'd0;
	localparam logic [1:0] reg_dst_rt = 2'd1;
	localparam logic [1:0] reg_dst_ra = 2'd2;

	// regimm rt[4:1] groups
	localparam logic [3:0] regimm_plain = 4'b0000; // bltz, bgez
	localparam logic [3:0] regimm_link  = 4'b1000; // bltzal, bgezal

	localparam logic [31:0] eret_word = 32'h4200_0018;

	typedef enum logic [5:0] {
		op_r_type = 6'h00, op_regimm = 6'h01, op_j    = 6'h02, op_jal   = 6'h03,
		op_beq    = 6'h04, op_bne    = 6'h05, op_blez = 6'h06, op_bgtz  = 6'h07,
		op_addi   = 6'h08, op_addiu  = 6'h09, op_slti = 6'h0a, op_sltiu = 6'h0b,
		op_andi   = 6'h0c, op_ori    = 6'h0d, op_xori = 6'h0e, op_lui   = 6'h0f,
		op_cop0   = 6'h10,
		op_lb     = 6'h20, op_lh     = 6'h21, op_lw   = 6'h23, op_lbu   = 6'h24,
		op_lhu    = 6'h25,
		op_sb     = 6'h28, op_sh     = 6'h29, op_sw   = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_sll     = 6'h00, fn_srl   = 6'h02, fn_sra   = 6'h03,
		fn_sllv    = 6'h04, fn_srlv  = 6'h06, fn_srav  = 6'h07,
		fn_jr      = 6'h08, fn_jalr  = 6'h09,
		fn_syscall = 6'h0c, fn_break = 6'h0d,
		fn_mfhi    = 6'h10, fn_mthi  = 6'h11, fn_mflo  = 6'h12, fn_mtlo = 6'h13,
		fn_mult    = 6'h18, fn_multu = 6'h19, fn_div   = 6'h1a, fn_divu = 6'h1b,
		fn_add     = 6'h20, fn_addu  = 6'h21, fn_sub   = 6'h22, fn_subu = 6'h23,
		fn_and     = 6'h24, fn_or    = 6'h25, fn_xor   = 6'h26, fn_nor  = 6'h27,
		fn_slt     = 6'h2a, fn_sltu  = 6'h2b
	} funct_e;

	// cop0 rs field
	typedef enum logic [4:0] {
		cp0_mfc0 = 5'h00,
		cp0_mtc0 = 5'h04,
		cp0_co   = 5'h10 // eret lives here
	} cp0_rs_e;

	// cause register ExcCode values
	typedef enum logic [4:0] {
		exc_none    = 5'd0,
		exc_syscall = 5'd8,
		exc_break   = 5'd9,
		exc_ri      = 5'd10
	} exc_code_e;

endpackage

`default_nettype wire

//--- rtl/main_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module main_decoder (
	input  wire        clk,
	input  wire        arst_n,
	input  wire [31:0] instr_d,
	input  wire        flush_e,
	input  wire        flush_m,
	output logic       sign_ext_d,
	output logic [1:0] reg_dst_e,
	output logic       alu_imm_sel_e,
	output logic       reg_write_en_e,
	output logic       hilo_wen_e,
	output logic       mem_read_en_e,
	output logic       mem_write_en_e,
	output logic       mem_read_en_m,
	output logic       mem_write_en_m,
	output logic       reg_write_en_m,
	output logic       mem_to_reg_m,
	output logic       hilo_to_reg_m,
	output logic       ri_m,
	output logic       break_m,
	output logic       syscall_m,
	output logic       eret_m,
	output logic       cp0_wen_m,
	output logic       cp0_to_reg_m
);

	mips_ctrl_pkg::opcode_e opcode;
	mips_ctrl_pkg::funct_e  funct;
	mips_ctrl_pkg::cp0_rs_e rs;
	logic [mips_ctrl_pkg::reg_addr_w-1:0] rt;

	logic [1:0] reg_dst_d;
	logic alu_imm_sel_d, reg_write_en_d, mem_read_en_d, mem_write_en_d, mem_to_reg_d;
	logic hilo_wen_d, hilo_to_reg_d, cp0_wen_d, cp0_to_reg_d;
	logic ri_d, break_d, syscall_d, eret_d;

	// E copies of bits that only surface in M
	logic mem_to_reg_e, hilo_to_reg_e, cp0_wen_e, cp0_to_reg_e;
	logic ri_e, break_e, syscall_e, eret_e;

	assign opcode = mips_ctrl_pkg::opcode_e'(instr_d[mips_ctrl_pkg::op_msb:mips_ctrl_pkg::op_lsb]);
	assign funct  = mips_ctrl_pkg::funct_e'(
		instr_d[mips_ctrl_pkg::funct_msb:mips_ctrl_pkg::funct_lsb]);
	assign rs     = mips_ctrl_pkg::cp0_rs_e'(instr_d[mips_ctrl_pkg::rs_msb:mips_ctrl_pkg::rs_lsb]);
	assign rt     = instr_d[mips_ctrl_pkg::rt_msb:mips_ctrl_pkg::rt_lsb];

	// logic immediates are zero extended
	assign sign_ext_d = !(opcode inside {mips_ctrl_pkg::op_andi, mips_ctrl_pkg::op_ori,
		mips_ctrl_pkg::op_xori, mips_ctrl_pkg::op_lui});

	always_comb begin
		reg_dst_d      = mips_ctrl_pkg::reg_dst_rd;
		alu_imm_sel_d  = 1'b0;
		reg_write_en_d = 1'b0;
		mem_read_en_d  = 1'b0;
		mem_write_en_d = 1'b0;
		mem_to_reg_d   = 1'b0;
		hilo_wen_d     = 1'b0;
		hilo_to_reg_d  = 1'b0;
		cp0_wen_d      = 1'b0;
		cp0_to_reg_d   = 1'b0;
		ri_d           = 1'b0;
		break_d        = 1'b0;
		syscall_d      = 1'b0;
		eret_d         = 1'b0;
		case (opcode)
			mips_ctrl_pkg::op_r_type: begin
				case (funct)
					mips_ctrl_pkg::fn_add, mips_ctrl_pkg::fn_addu, mips_ctrl_pkg::fn_sub,
					mips_ctrl_pkg::fn_subu, mips_ctrl_pkg::fn_slt, mips_ctrl_pkg::fn_sltu,
					mips_ctrl_pkg::fn_and, mips_ctrl_pkg::fn_or, mips_ctrl_pkg::fn_xor,
					mips_ctrl_pkg::fn_nor, mips_ctrl_pkg::fn_sll, mips_ctrl_pkg::fn_srl,
					mips_ctrl_pkg::fn_sra, mips_ctrl_pkg::fn_sllv, mips_ctrl_pkg::fn_srlv,
					mips_ctrl_pkg::fn_srav:
						reg_write_en_d = 1'b1; // writes rd
					mips_ctrl_pkg::fn_mfhi, mips_ctrl_pkg::fn_mflo: begin
						reg_write_en_d = 1'b1;
						hilo_to_reg_d  = 1'b1;
					end
					mips_ctrl_pkg::fn_mult, mips_ctrl_pkg::fn_multu, mips_ctrl_pkg::fn_div,
					mips_ctrl_pkg::fn_divu, mips_ctrl_pkg::fn_mthi, mips_ctrl_pkg::fn_mtlo:
						hilo_wen_d = 1'b1;
					mips_ctrl_pkg::fn_jr: ; // no register or memory effect
					mips_ctrl_pkg::fn_jalr: begin
						reg_write_en_d = 1'b1; // link always goes to $ra here
						reg_dst_d      = mips_ctrl_pkg::reg_dst_ra;
					end
					mips_ctrl_pkg::fn_syscall: syscall_d = 1'b1;
					mips_ctrl_pkg::fn_break:   break_d   = 1'b1;
					default: ri_d = 1'b1;
				endcase
			end
			mips_ctrl_pkg::op_regimm: begin
				if (rt[4:1] == mips_ctrl_pkg::regimm_link) begin
					reg_write_en_d = 1'b1;
					reg_dst_d      = mips_ctrl_pkg::reg_dst_ra;
				end else if (rt[4:1] != mips_ctrl_pkg::regimm_plain) begin
					ri_d = 1'b1;
				end
			end
			mips_ctrl_pkg::op_j, mips_ctrl_pkg::op_beq, mips_ctrl_pkg::op_bne,
			mips_ctrl_pkg::op_blez, mips_ctrl_pkg::op_bgtz: ; // resolved elsewhere
			mips_ctrl_pkg::op_jal: begin
				reg_write_en_d = 1'b1;
				reg_dst_d      = mips_ctrl_pkg::reg_dst_ra;
			end
			mips_ctrl_pkg::op_addi, mips_ctrl_pkg::op_addiu, mips_ctrl_pkg::op_slti,
			mips_ctrl_pkg::op_sltiu, mips_ctrl_pkg::op_andi, mips_ctrl_pkg::op_ori,
			mips_ctrl_pkg::op_xori, mips_ctrl_pkg::op_lui: begin
				reg_write_en_d = 1'b1;
				reg_dst_d      = mips_ctrl_pkg::reg_dst_rt;
				alu_imm_sel_d  = 1'b1;
			end
			mips_ctrl_pkg::op_lb, mips_ctrl_pkg::op_lh, mips_ctrl_pkg::op_lw,
			mips_ctrl_pkg::op_lbu, mips_ctrl_pkg::op_lhu: begin
				reg_write_en_d = 1'b1;
				reg_dst_d      = mips_ctrl_pkg::reg_dst_rt;
				alu_imm_sel_d  = 1'b1; // address = base + offset
				mem_read_en_d  = 1'b1;
				mem_to_reg_d   = 1'b1;
			end
			mips_ctrl_pkg::op_sb, mips_ctrl_pkg::op_sh, mips_ctrl_pkg::op_sw: begin
				alu_imm_sel_d  = 1'b1;
				mem_write_en_d = 1'b1;
			end
			mips_ctrl_pkg::op_cop0: begin
				case (rs)
					mips_ctrl_pkg::cp0_mfc0: begin
						reg_write_en_d = 1'b1;
						reg_dst_d      = mips_ctrl_pkg::reg_dst_rt;
						cp0_to_reg_d   = 1'b1;
					end
					mips_ctrl_pkg::cp0_mtc0: cp0_wen_d = 1'b1;
					mips_ctrl_pkg::cp0_co: begin
						eret_d = (instr_d == mips_ctrl_pkg::eret_word);
						ri_d   = (instr_d != mips_ctrl_pkg::eret_word); // other co ops unsupported
					end
					default: ri_d = 1'b1;
				endcase
			end
			default: ri_d = 1'b1;
		endcase
	end

	// ID/EX
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{reg_dst_e, alu_imm_sel_e, reg_write_en_e, hilo_wen_e} <= '0;
			{mem_read_en_e, mem_write_en_e, mem_to_reg_e, hilo_to_reg_e} <= '0;
			{cp0_wen_e, cp0_to_reg_e, ri_e, break_e, syscall_e, eret_e} <= '0;
		end else if (flush_e) begin // bubble
			{reg_dst_e, alu_imm_sel_e, reg_write_en_e, hilo_wen_e} <= '0;
			{mem_read_en_e, mem_write_en_e, mem_to_reg_e, hilo_to_reg_e} <= '0;
			{cp0_wen_e, cp0_to_reg_e, ri_e, break_e, syscall_e, eret_e} <= '0;
		end else begin
			reg_dst_e      <= reg_dst_d;
			alu_imm_sel_e  <= alu_imm_sel_d;
			reg_write_en_e <= reg_write_en_d;
			hilo_wen_e     <= hilo_wen_d;
			mem_read_en_e  <= mem_read_en_d;
			mem_write_en_e <= mem_write_en_d;
			mem_to_reg_e   <= mem_to_reg_d;
			hilo_to_reg_e  <= hilo_to_reg_d;
			cp0_wen_e      <= cp0_wen_d;
			cp0_to_reg_e   <= cp0_to_reg_d;
			{ri_e, break_e, syscall_e, eret_e} <= {ri_d, break_d, syscall_d, eret_d};
		end
	end

	// EX/MEM
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			{mem_read_en_m, mem_write_en_m, reg_write_en_m, mem_to_reg_m} <= '0;
			{hilo_to_reg_m, cp0_wen_m, cp0_to_reg_m} <= '0;
			{ri_m, break_m, syscall_m, eret_m} <= '0;
		end else if (flush_m) begin
			{mem_read_en_m, mem_write_en_m, reg_write_en_m, mem_to_reg_m} <= '0;
			{hilo_to_reg_m, cp0_wen_m, cp0_to_reg_m} <= '0;
			{ri_m, break_m, syscall_m, eret_m} <= '0;
		end else begin
			mem_read_en_m  <= mem_read_en_e;
			mem_write_en_m <= mem_write_en_e;
			reg_write_en_m <= reg_write_en_e;
			mem_to_reg_m   <= mem_to_reg_e;
			hilo_to_reg_m  <= hilo_to_reg_e;
			cp0_wen_m      <= cp0_wen_e;
			cp0_to_reg_m   <= cp0_to_reg_e;
			{ri_m, break_m, syscall_m, eret_m} <= {ri_e, break_e, syscall_e, eret_e};
		end
	end

	a_no_rd_wr_e: assert property (@(posedge clk) disable iff (!arst_n)
		!(mem_read_en_e && mem_write_en_e));

	// exception unit relies on one cause per instruction
	a_one_exc_m: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({ri_m, break_m, syscall_m, eret_m}));

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module hazard_unit (
	input  wire        clk,
	input  wire        arst_n,
	input  wire [31:0] instr_d,
	input  wire        mem_read_en_e,
	input  wire        exc_flush,
	output logic       stall_d,
	output logic       flush_e
);

	logic [mips_ctrl_pkg::reg_addr_w-1:0] rs_d, rt_d;
	logic [mips_ctrl_pkg::reg_addr_w-1:0] rt_e; // load target of the instruction in E

	assign rs_d = instr_d[mips_ctrl_pkg::rs_msb:mips_ctrl_pkg::rs_lsb];
	assign rt_d = instr_d[mips_ctrl_pkg::rt_msb:mips_ctrl_pkg::rt_lsb];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rt_e <= '0;
		else if (flush_e)
			rt_e <= '0; // bubble carries no destination
		else
			rt_e <= rt_d;
	end

	// $zero never causes a load-use stall
	assign stall_d = mem_read_en_e && (rt_e != '0) && ((rt_e == rs_d) || (rt_e == rt_d))
		&& !exc_flush;
	assign flush_e = stall_d || exc_flush;

	// decoder must turn the stalled load into a bubble
	a_stall_bubble: assert property (@(posedge clk) disable iff (!arst_n)
		stall_d |=> !mem_read_en_e);

endmodule

`default_nettype wire

//--- rtl/exception_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exception_unit (
	input  wire                      ri_m,
	input  wire                      break_m,
	input  wire                      syscall_m,
	input  wire                      eret_m,
	output logic                     exc_valid,
	output mips_ctrl_pkg::exc_code_e exc_code,
	output logic                     exc_flush
);

	// fixed priority, ri first
	always_comb begin
		if (ri_m)
			exc_code = mips_ctrl_pkg::exc_ri;
		else if (break_m)
			exc_code = mips_ctrl_pkg::exc_break;
		else if (syscall_m)
			exc_code = mips_ctrl_pkg::exc_syscall;
		else
			exc_code = mips_ctrl_pkg::exc_none;
	end

	assign exc_valid = (exc_code != mips_ctrl_pkg::exc_none);

	// eret is not an exception but still redirects fetch
	assign exc_flush = exc_valid || eret_m;

endmodule

`default_nettype wire

//--- rtl/mips_ctrl_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_ctrl_top (
	input  wire                      clk,
	input  wire                      arst_n,
	input  wire [31:0]               instr_d,
	output logic                     stall_d,
	output logic                     sign_ext_d,
	output logic [1:0]               reg_dst_e,
	output logic                     alu_imm_sel_e,
	output logic                     reg_write_en_e,
	output logic                     hilo_wen_e,
	output logic                     mem_read_en_e,
	output logic                     mem_write_en_e,
	output logic                     mem_read_en_m,
	output logic                     mem_write_en_m,
	output logic                     reg_write_en_m,
	output logic                     mem_to_reg_m,
	output logic                     hilo_to_reg_m,
	output logic                     ri_m,
	output logic                     break_m,
	output logic                     syscall_m,
	output logic                     eret_m,
	output logic                     cp0_wen_m,
	output logic                     cp0_to_reg_m,
	output logic                     exc_valid,
	output mips_ctrl_pkg::exc_code_e exc_code
);

	logic flush_e;   // from hazard unit
	logic exc_flush; // squashes E and M

	main_decoder u_main_decoder (
		.clk            (clk),
		.arst_n         (arst_n),
		.instr_d        (instr_d),
		.flush_e        (flush_e),
		.flush_m        (exc_flush),
		.sign_ext_d     (sign_ext_d),
		.reg_dst_e      (reg_dst_e),
		.alu_imm_sel_e  (alu_imm_sel_e),
		.reg_write_en_e (reg_write_en_e),
		.hilo_wen_e     (hilo_wen_e),
		.mem_read_en_e  (mem_read_en_e),
		.mem_write_en_e (mem_write_en_e),
		.mem_read_en_m  (mem_read_en_m),
		.mem_write_en_m (mem_write_en_m),
		.reg_write_en_m (reg_write_en_m),
		.mem_to_reg_m   (mem_to_reg_m),
		.hilo_to_reg_m  (hilo_to_reg_m),
		.ri_m           (ri_m),
		.break_m        (break_m),
		.syscall_m      (syscall_m),
		.eret_m         (eret_m),
		.cp0_wen_m      (cp0_wen_m),
		.cp0_to_reg_m   (cp0_to_reg_m)
	);

	hazard_unit u_hazard_unit (
		.clk           (clk),
		.arst_n        (arst_n),
		.instr_d       (instr_d),
		.mem_read_en_e (mem_read_en_e),
		.exc_flush     (exc_flush),
		.stall_d       (stall_d),
		.flush_e       (flush_e)
	);

	exception_unit u_exception_unit (
		.ri_m      (ri_m),
		.break_m   (break_m),
		.syscall_m (syscall_m),
		.eret_m    (eret_m),
		.exc_valid (exc_valid),
		.exc_code  (exc_code),
		.exc_flush (exc_flush)
	);

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk    = 1'b0;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1; // two full periods in reset
	end

	always #10 clk = ~clk; // 20 ns period

endmodule

`default_nettype wire

//--- testbench/tb_mips_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_ctrl;

	logic clk;
	logic arst_n;
	logic [31:0] instr_d;
	logic stall_d;
	logic sign_ext_d;
	logic [1:0] reg_dst_e;
	logic alu_imm_sel_e;
	logic reg_write_en_e;
	logic hilo_wen_e;
	logic mem_read_en_e;
	logic mem_write_en_e;
	logic mem_read_en_m;
	logic mem_write_en_m;
	logic reg_write_en_m;
	logic mem_to_reg_m;
	logic hilo_to_reg_m;
	logic ri_m;
	logic break_m;
	logic syscall_m;
	logic eret_m;
	logic cp0_wen_m;
	logic cp0_to_reg_m;
	logic exc_valid;
	mips_ctrl_pkg::exc_code_e exc_code;

	// stimulus table, row 0 doubles as the all-zero bubble
	// e: [6:5] reg_dst [4] alu_imm [3] reg_we [2] hilo_wen [1] mem_rd [0] mem_wr
	// m: [10] mem_rd [9] mem_wr [8] reg_we [7] mem_to_reg [6] hilo_to_reg
	//    [5] ri [4] break [3] syscall [2] eret [1] cp0_wen [0] cp0_to_reg
	logic [31:0] row_instr[$];
	logic [6:0]  row_e[$];
	logic [10:0] row_m[$];
	logic [4:0]  row_x[$];
	logic        row_sext[$];

	int pipe_q[$]; // [0] row in E, [1] row in M
	logic [31:0] rng_state = 32'h20b9;
	bit table_ready = 1'b0;

	tb_clock_gen u_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	mips_ctrl_top i_dut (
		.clk            (clk),
		.arst_n         (arst_n),
		.instr_d        (instr_d),
		.stall_d        (stall_d),
		.sign_ext_d     (sign_ext_d),
		.reg_dst_e      (reg_dst_e),
		.alu_imm_sel_e  (alu_imm_sel_e),
		.reg_write_en_e (reg_write_en_e),
		.hilo_wen_e     (hilo_wen_e),
		.mem_read_en_e  (mem_read_en_e),
		.mem_write_en_e (mem_write_en_e),
		.mem_read_en_m  (mem_read_en_m),
		.mem_write_en_m (mem_write_en_m),
		.reg_write_en_m (reg_write_en_m),
		.mem_to_reg_m   (mem_to_reg_m),
		.hilo_to_reg_m  (hilo_to_reg_m),
		.ri_m           (ri_m),
		.break_m        (break_m),
		.syscall_m      (syscall_m),
		.eret_m         (eret_m),
		.cp0_wen_m      (cp0_wen_m),
		.cp0_to_reg_m   (cp0_to_reg_m),
		.exc_valid      (exc_valid),
		.exc_code       (exc_code)
	);

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic pick_reg(output logic [4:0] r);
		rng_state = next_random(rng_state);
		r = rng_state[4:0];
	endtask

	task automatic add_row(input logic [31:0] instr, input logic [6:0] e, input logic [10:0] m,
		input logic [4:0] x, input logic sext);
		row_instr.push_back(instr);
		row_e.push_back(e);
		row_m.push_back(m);
		row_x.push_back(x);
		row_sext.push_back(sext);
	endtask

	// R-type ALU op with random registers
	task automatic add_alu_row(input mips_ctrl_pkg::funct_e fn);
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		pick_reg(rs);
		pick_reg(rt);
		pick_reg(rd);
		add_row({mips_ctrl_pkg::op_r_type, rs, rt, rd, 5'd0, fn}, 7'h08, 11'h100,
			mips_ctrl_pkg::exc_none, 1'b1);
	endtask

	// the faulting word, the victim in E and the word dropped from D
	task automatic add_exception_rows(input logic [31:0] word, input logic [10:0] m,
		input logic [4:0] x);
		add_row(word, 7'h00, m, x, 1'b1);
		add_row({mips_ctrl_pkg::op_addiu, 5'd1, 5'd2, 16'h0001}, 7'h38, 11'h100,
			mips_ctrl_pkg::exc_none, 1'b1);
		add_row({mips_ctrl_pkg::op_ori, 5'd6, 5'd5, 16'h00ff}, 7'h38, 11'h100,
			mips_ctrl_pkg::exc_none, 1'b0);
	endtask

	task automatic build_table();
		logic [4:0] none;
		none = mips_ctrl_pkg::exc_none;
		add_row({mips_ctrl_pkg::op_beq, 26'd0}, 7'h00, 11'h000, none, 1'b1); // nop
		add_alu_row(mips_ctrl_pkg::fn_add);
		add_alu_row(mips_ctrl_pkg::fn_subu);
		add_alu_row(mips_ctrl_pkg::fn_nor);
		add_alu_row(mips_ctrl_pkg::fn_srav);
		add_row({mips_ctrl_pkg::op_r_type, 10'd0, 5'd4, 5'd0, mips_ctrl_pkg::fn_mfhi},
			7'h08, 11'h140, none, 1'b1);
		add_row({mips_ctrl_pkg::op_r_type, 5'd4, 5'd5, 10'd0, mips_ctrl_pkg::fn_mult},
			7'h04, 11'h000, none, 1'b1);
		add_row({mips_ctrl_pkg::op_r_type, 5'd31, 15'd0, mips_ctrl_pkg::fn_jr},
			7'h00, 11'h000, none, 1'b1);
		add_row({mips_ctrl_pkg::op_r_type, 5'd6, 5'd0, 5'd31, 5'd0, mips_ctrl_pkg::fn_jalr},
			7'h48, 11'h100, none, 1'b1);
		add_row({mips_ctrl_pkg::op_addiu, 5'd1, 5'd2, 16'hfff0}, 7'h38, 11'h100, none, 1'b1);
		add_row({mips_ctrl_pkg::op_slti, 5'd3, 5'd4, 16'h0010}, 7'h38, 11'h100, none, 1'b1);
		add_row({mips_ctrl_pkg::op_andi, 5'd3, 5'd5, 16'h00f0}, 7'h38, 11'h100, none, 1'b0);
		add_row({mips_ctrl_pkg::op_ori, 5'd3, 5'd6, 16'h8000}, 7'h38, 11'h100, none, 1'b0);
		add_row({mips_ctrl_pkg::op_xori, 5'd3, 5'd7, 16'h1234}, 7'h38, 11'h100, none, 1'b0);
		add_row({mips_ctrl_pkg::op_lui, 5'd0, 5'd7, 16'hbeef}, 7'h38, 11'h100, none, 1'b0);
		add_row({mips_ctrl_pkg::op_lb, 5'd29, 5'd12, 16'h0001}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_lhu, 5'd29, 5'd13, 16'h0002}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_lw, 5'd29, 5'd2, 16'h0010}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_sw, 5'd29, 5'd3, 16'h0008}, 7'h11, 11'h200, none, 1'b1);
		add_row({mips_ctrl_pkg::op_jal, 26'h40}, 7'h48, 11'h100, none, 1'b1);
		add_row({mips_ctrl_pkg::op_regimm, 5'd7, 5'b10000, 16'h0004}, 7'h48, 11'h100, none,
			1'b1); // bltzal
		add_row({mips_ctrl_pkg::op_regimm, 5'd7, 5'b00001, 16'h0004}, 7'h00, 11'h000, none,
			1'b1); // bgez
		add_row({mips_ctrl_pkg::op_j, 26'h80}, 7'h00, 11'h000, none, 1'b1);
		add_row({mips_ctrl_pkg::op_cop0, mips_ctrl_pkg::cp0_mfc0, 5'd9, 5'd12, 11'd0},
			7'h28, 11'h101, none, 1'b1);
		add_row({mips_ctrl_pkg::op_cop0, mips_ctrl_pkg::cp0_mtc0, 5'd9, 5'd14, 11'd0},
			7'h00, 11'h002, none, 1'b1);
		// load-use pairs, rs match then rt match, then $zero
		add_row({mips_ctrl_pkg::op_lw, 5'd29, 5'd8, 16'h0004}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_r_type, 5'd8, 5'd10, 5'd9, 5'd0, mips_ctrl_pkg::fn_add},
			7'h08, 11'h100, none, 1'b1);
		add_row({mips_ctrl_pkg::op_lw, 5'd29, 5'd11, 16'h0000}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_sw, 5'd4, 5'd11, 16'h0004}, 7'h11, 11'h200, none, 1'b1);
		add_row({mips_ctrl_pkg::op_lw, 5'd5, 5'd0, 16'h0000}, 7'h3a, 11'h580, none, 1'b1);
		add_row({mips_ctrl_pkg::op_r_type, 5'd0, 5'd0, 5'd3, 5'd0, mips_ctrl_pkg::fn_add},
			7'h08, 11'h100, none, 1'b1);
		add_exception_rows(32'hfc00_0000, 11'h020, mips_ctrl_pkg::exc_ri);
		add_exception_rows({mips_ctrl_pkg::op_r_type, 20'd0, mips_ctrl_pkg::fn_break},
			11'h010, mips_ctrl_pkg::exc_break);
		add_exception_rows({mips_ctrl_pkg::op_r_type, 20'd0, mips_ctrl_pkg::fn_syscall},
			11'h008, mips_ctrl_pkg::exc_syscall);
		add_exception_rows(mips_ctrl_pkg::eret_word, 11'h004, none);
		add_row({mips_ctrl_pkg::op_beq, 26'd0}, 7'h00, 11'h000, none, 1'b1); // drain
		add_row({mips_ctrl_pkg::op_beq, 26'd0}, 7'h00, 11'h000, none, 1'b1);
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic check_outputs(input int e_row, input int m_row, input logic stall_exp,
		input int d_row, input string tag);
		check_value(32'({reg_dst_e, alu_imm_sel_e, reg_write_en_e, hilo_wen_e, mem_read_en_e,
			mem_write_en_e}), 32'(row_e[e_row]), {tag, ", E bits"});
		check_value(32'({mem_read_en_m, mem_write_en_m, reg_write_en_m, mem_to_reg_m,
			hilo_to_reg_m, ri_m, break_m, syscall_m, eret_m, cp0_wen_m, cp0_to_reg_m}),
			32'(row_m[m_row]), {tag, ", M bits"});
		check_value(32'(exc_code), 32'(row_x[m_row]), {tag, ", exc_code"});
		check_value(32'(exc_valid), 32'(row_x[m_row] != 5'd0), {tag, ", exc_valid"});
		check_value(32'(stall_d), 32'(stall_exp), {tag, ", stall_d"});
		check_value(32'(sign_ext_d), 32'(row_sext[d_row]), {tag, ", sign_ext_d"});
	endtask

	initial begin
		int pos;
		int e_row;
		int m_row;
		logic flush;
		logic stall;
		logic [4:0] rt_e;
		build_table();
		instr_d <= row_instr[0];
		pipe_q.push_back(0);
		pipe_q.push_back(0);
		table_ready = 1'b1;
		@(negedge clk); // still in reset
		check_outputs(0, 0, 1'b0, 0, "reset");
		wait (arst_n === 1'b1);
		pos = 0;
		while (pos < row_instr.size()) begin
			e_row = pipe_q[0];
			m_row = pipe_q[1];
			flush = (row_x[m_row] != 5'd0) || row_m[m_row][2]; // exception or eret in M
			rt_e  = row_instr[e_row][20:16];
			stall = !flush && row_e[e_row][1] && (rt_e != 5'd0)
				&& ((rt_e == row_instr[pos][25:21]) || (rt_e == row_instr[pos][20:16]));
			check_outputs(e_row, m_row, stall, pos, $sformatf("row %0d in D", pos));
			pipe_q.delete(1);
			if (flush)
				pipe_q[0] = 0; // E never reaches M
			pipe_q.push_front((flush || stall) ? 0 : pos);
			if (!stall)
				pos++;
			if (pos < row_instr.size()) begin
				@(posedge clk);
				instr_d <= row_instr[pos]; // same word again while stalled
				@(negedge clk);
			end
		end
		$display(">>> PASS");
		$finish;
	end

	// 40 cycles per row plus reset
	initial begin
		wait (table_ready);
		repeat (row_instr.size() * 40 + 4) @(posedge clk);
		$display("watchdog expired, the run hung before all rows were applied");
		$display(">>> FAIL");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

//--- all.f
rtl/mips_ctrl_pkg.sv
rtl/main_decoder.sv
rtl/hazard_unit.sv
rtl/exception_unit.sv
rtl/mips_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_mips_ctrl.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f all.f --top-module tb_mips_ctrl
out=$(./obj_dir/Vtb_mips_ctrl 2>&1) || true
echo "$out"
if echo "$out" | grep -qx '>>> PASS'; then
	exit 0
else
	exit 1
fi
